// File: Makefile
VERILATOR  ?= verilator
TOP        := arcade_video_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/arcade_video_top.sv
// Video and settings front end; hlen must be 8 or more, and pxl2_cen should tick twice per pxl_cen
`timescale 1ns/1ps
`include "video_defs.svh"

module arcade_video_top
    import video_pkg::*;
#(
    parameter int hlen = `SCAN_HLEN
) (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic              pxl2_cen,
    input  logic [`PXL_W-1:0] pxl,        // Native 3-3-2 pixel from the core
    input  logic              hs,
    input  logic              vs,
    input  logic [31:0]       status,     // Menu status word
    input  logic              game_pause,
    output logic [5:0]        vga_r,
    output logic [5:0]        vga_g,
    output logic [5:0]        vga_b,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_cen,
    output level_e            dip_level,
    output logic [1:0]        dip_lives,
    output logic              dip_pause,
    output logic              rst_req
);

    logic              filter_en;
    logic [`PXL_W-1:0] x2_pxl;
    logic              x2_hs;
    logic              x2_cen;
    logic              second_pass;

    dip_decoder u_dip (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .status     (status),
        .game_pause (game_pause),
        .dip_level  (dip_level),
        .dip_lives  (dip_lives),
        .dip_pause  (dip_pause),
        .filter_en  (filter_en),
        .rst_req    (rst_req)
    );

    line_doubler #(
        .hlen (hlen)
    ) u_doubler (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .pxl_cen     (pxl_cen),
        .pxl2_cen    (pxl2_cen),
        .pxl         (pxl),
        .hs          (hs),
        .x2_pxl      (x2_pxl),
        .x2_hs       (x2_hs),
        .x2_cen      (x2_cen),
        .second_pass (second_pass)
    );

    vga_mixer u_mixer (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .filter_en   (filter_en),
        .x2_pxl      (x2_pxl),
        .x2_hs       (x2_hs),
        .x2_cen      (x2_cen),
        .second_pass (second_pass),
        .vs          (vs),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_cen     (vga_cen)
    );

endmodule

// File: rtl/dip_decoder.sv
// Menu settings decoder; all outputs lag status by one clk_sys cycle, and dip_pause is active high (halt)
`timescale 1ns/1ps
`include "video_defs.svh"

module dip_decoder
    import video_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [31:0] status,     // Menu status word
    input  logic        game_pause, // Pause request from the cabinet
    output level_e      dip_level,
    output logic [1:0]  dip_lives,
    output logic        dip_pause,
    output logic        filter_en,
    output logic        rst_req
);

    logic [1:0] menu_level;  // Difficulty in menu order
    logic [1:0] menu_lives;
    logic       menu_pause;
    logic       menu_filter; // 1 means filter off
    logic       menu_reset;

    // Raw fields of the status word
    always_comb begin
        menu_level  = status[`ST_LEVEL_LO +: 2];
        menu_lives  = status[`ST_LIVES_LO +: 2];
        menu_pause  = status[`ST_PAUSE];
        menu_filter = status[`ST_FILTER];
        menu_reset  = status[`ST_RESET];
    end

    // Registered settings for the core and the mixer
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            dip_level <= LEVEL_NORMAL;
            dip_lives <= 2'd0;
            dip_pause <= 1'b0;
            filter_en <= 1'b1;   // Filter on until the menu says otherwise
            rst_req   <= 1'b0;
        end else begin
            dip_level <= level_from_menu(menu_level);
            dip_lives <= menu_lives;
            // Either source halts the game
            dip_pause <= menu_pause | game_pause;
            filter_en <= ~menu_filter;
            rst_req   <= menu_reset;
        end
    end

endmodule

// File: rtl/line_doubler.sv
// Line doubler; needs hlen >= 8, plays line N twice during native line N+1, and outputs 0 until one full line is stored
`timescale 1ns/1ps
`include "video_defs.svh"

module line_doubler
    import video_pkg::*;
#(
    parameter int hlen = `SCAN_HLEN
) (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              pxl_cen,     // Native pixel tick
    input  logic              pxl2_cen,    // Doubled pixel tick
    input  logic [`PXL_W-1:0] pxl,
    input  logic              hs,
    output logic [`PXL_W-1:0] x2_pxl,
    output logic              x2_hs,
    output logic              x2_cen,
    output logic              second_pass  // Sample belongs to the repeated pass
);

    localparam int aw = $clog2(hlen);
    localparam logic [aw-1:0] last_addr = aw'(hlen - 1);

    // Two line banks, indexed by bank_e
    logic [`PXL_W-1:0] mem [0:1][0:hlen-1];

    logic          hs_l;
    logic          hs_rise;
    bank_e         wr_bank;
    bank_e         wr_bank_now;
    bank_e         rd_bank_now;
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] wr_addr_now;
    logic [aw-1:0] rd_addr;
    logic [aw-1:0] rd_addr_now;
    logic          wr_full;      // Whole line written into the write bank
    logic          wr_full_now;
    logic          rd_pass;      // Reading the second copy
    logic          rd_pass_now;
    logic          rd_done;      // Both passes played
    logic          rd_done_now;
    logic          line_valid;   // A complete line has been stored since reset
    logic          line_valid_now;

    // State as seen by this cycle's accesses
    // An hs edge takes effect at once, so a tick in the same cycle uses address 0
    always_comb begin
        hs_rise = hs & ~hs_l;
        if (hs_rise) begin
            wr_bank_now    = other_bank(wr_bank);
            wr_addr_now    = '0;
            wr_full_now    = 1'b0;
            rd_addr_now    = '0;
            rd_pass_now    = 1'b0;
            rd_done_now    = 1'b0;
            line_valid_now = line_valid | wr_full; // Finished line becomes the read bank
        end else begin
            wr_bank_now    = wr_bank;
            wr_addr_now    = wr_addr;
            wr_full_now    = wr_full;
            rd_addr_now    = rd_addr;
            rd_pass_now    = rd_pass;
            rd_done_now    = rd_done;
            line_valid_now = line_valid;
        end
        rd_bank_now = other_bank(wr_bank_now);
    end

    // Line store, extra pixels past hlen are dropped
    always_ff @(posedge clk_sys) begin
        if (pxl_cen && !wr_full_now)
            mem[wr_bank_now][wr_addr_now] <= pxl;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hs_l        <= 1'b0;
            wr_bank     <= BANK_A;
            wr_addr     <= '0;
            wr_full     <= 1'b0;
            rd_addr     <= '0;
            rd_pass     <= 1'b0;
            rd_done     <= 1'b1;    // Nothing to play before the first hs
            line_valid  <= 1'b0;
            x2_pxl      <= '0;
            x2_hs       <= 1'b0;
            x2_cen      <= 1'b0;
            second_pass <= 1'b0;
        end else begin
            hs_l       <= hs;
            wr_bank    <= wr_bank_now;
            wr_addr    <= wr_addr_now;
            wr_full    <= wr_full_now;
            rd_addr    <= rd_addr_now;
            rd_pass    <= rd_pass_now;
            rd_done    <= rd_done_now;
            line_valid <= line_valid_now;
            x2_cen     <= 1'b0;     // One-cycle pulse

            if (pxl_cen && !wr_full_now) begin
                if (wr_addr_now == last_addr)
                    wr_full <= 1'b1;
                else
                    wr_addr <= wr_addr_now + 1'b1;
            end

            // Playback, extra doubled ticks after the second pass are ignored
            if (pxl2_cen && !rd_done_now) begin
                x2_pxl      <= line_valid_now ? mem[rd_bank_now][rd_addr_now] : '0;
                x2_hs       <= (int'(rd_addr_now) < `X2_HS_LEN);
                x2_cen      <= 1'b1;
                second_pass <= rd_pass_now;
                if (rd_addr_now == last_addr) begin
                    rd_addr <= '0;
                    if (rd_pass_now)
                        rd_done <= 1'b1;
                    else
                        rd_pass <= 1'b1;
                end else begin
                    rd_addr <= rd_addr_now + 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/vga_mixer.sv
// VGA mixer; one register stage after the doubler, vs passes through that same stage only
`timescale 1ns/1ps
`include "video_defs.svh"

module vga_mixer (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              filter_en,   // Scan-line dimming on
    input  logic [`PXL_W-1:0] x2_pxl,      // 3-3-2 pixel from the doubler
    input  logic              x2_hs,
    input  logic              x2_cen,
    input  logic              second_pass,
    input  logic              vs,
    output logic [5:0]        vga_r,
    output logic [5:0]        vga_g,
    output logic [5:0]        vga_b,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_cen
);

    logic [2:0] red3;
    logic [2:0] green3;
    logic [1:0] blue2;
    logic [5:0] red6;
    logic [5:0] green6;
    logic [5:0] blue6;
    logic       dim;
    logic [5:0] red_mix;
    logic [5:0] green_mix;
    logic [5:0] blue_mix;

    always_comb begin
        red3   = x2_pxl[7:5];
        green3 = x2_pxl[4:2];
        blue2  = x2_pxl[1:0];

        // Bit repetition keeps full scale, 7 maps to 63
        red6   = {red3, red3};
        green6 = {green3, green3};
        blue6  = {3{blue2}};

        // Darken the repeated line of each pair
        dim = filter_en & second_pass;

        red_mix   = dim ? (red6 >> 1) : red6;
        green_mix = dim ? (green6 >> 1) : green6;
        blue_mix  = dim ? (blue6 >> 1) : blue6;
    end

    // Pixels and syncs share one register so they stay aligned
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vga_r   <= 6'd0;
            vga_g   <= 6'd0;
            vga_b   <= 6'd0;
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
            vga_cen <= 1'b0;
        end else begin
            vga_r   <= red_mix;
            vga_g   <= green_mix;
            vga_b   <= blue_mix;
            vga_hs  <= x2_hs;
            vga_vs  <= vs;      // Vertical timing is unchanged
            vga_cen <= x2_cen;
        end
    end

endmodule

// File: rtl/video_defs.svh
// Video constants; X2_HS_LEN counts doubled ticks per pass, and a line shorter than that gives a sync as long as the pass
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Native pixel, 3-3-2 order red, green, blue
`define PXL_W 8

// Native pixels per line when hlen is left at its default
`define SCAN_HLEN 322

// Doubled sync width in doubled pixel ticks, from the start of each pass
`define X2_HS_LEN 24

// Bit positions in the 32-bit menu status word
`define ST_PAUSE 1

// Difficulty, two bits from here up
`define ST_LEVEL_LO 2

// Lives, two bits from here up
`define ST_LIVES_LO 5

// Screen filter, menu value 1 turns it off
`define ST_FILTER 9

// Reset request from the menu
`define ST_RESET 15

`endif

// File: rtl/video_pkg.sv
// Types shared by the video front end; level_e is the core's encoding, not the menu order
package video_pkg;

    // Difficulty as the game core reads it
    typedef enum logic [1:0] {
        LEVEL_EASY      = 2'd0,
        LEVEL_NORMAL    = 2'd1,
        LEVEL_HARD      = 2'd2,
        LEVEL_VERY_HARD = 2'd3
    } level_e;

    // Line buffer half that is being written
    // The other half is the one played back
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_e;

    // Menu lists normal first, so codes 0 and 1 swap
    function automatic level_e level_from_menu(input logic [1:0] code);
        level_e lvl;
        case (code)
            2'd0:    lvl = LEVEL_NORMAL;
            2'd1:    lvl = LEVEL_EASY;
            2'd2:    lvl = LEVEL_HARD;
            default: lvl = LEVEL_VERY_HARD;
        endcase
        return lvl;
    endfunction

    // Bank that is read while the given bank is written
    function automatic bank_e other_bank(input bank_e bank);
        return (bank == BANK_A) ? BANK_B : BANK_A;
    endfunction

endpackage

// File: sources.f
+incdir+rtl
rtl/video_pkg.sv
rtl/dip_decoder.sv
rtl/line_doubler.sv
rtl/vga_mixer.sv
rtl/arcade_video_top.sv
testbench/arcade_video_chk.sv
testbench/arcade_video_tb.sv

// File: testbench/arcade_video_chk.sv
// Bound checker for arcade_video_top; line_valid and rd_done come from the doubler's next-state terms
`timescale 1ns/1ps

module arcade_video_chk (
    input logic clk_sys,
    input logic rst_n,
    input logic pxl2_cen,
    input logic line_valid,  // Stored line ready for playback
    input logic rd_done,     // Both passes already played
    input logic vga_cen,
    input logic vga_hs
);

    // Outputs settle to 0 after the first reset edge
    property reset_quiet;
        @(posedge clk_sys) (!rst_n ##1 !rst_n) |-> (!vga_cen && !vga_hs);
    endproperty

    // vga_cen is a single-cycle strobe
    property cen_pulse;
        @(posedge clk_sys) disable iff (!rst_n)
            vga_cen |=> !vga_cen;
    endproperty

    // Doubler stage plus mixer stage
    property cen_latency;
        @(posedge clk_sys) disable iff (!rst_n)
            (pxl2_cen && line_valid && !rd_done) |-> ##2 vga_cen;
    endproperty

    a_reset_quiet: assert property (reset_quiet)
        else $error("vga_cen or vga_hs high during reset");

    a_cen_pulse: assert property (cen_pulse)
        else $error("vga_cen high for two cycles in a row");

    a_cen_latency: assert property (cen_latency)
        else $error("vga_cen missing two cycles after pxl2_cen");

endmodule

// File: testbench/arcade_video_tb.sv
// Directed testbench for arcade_video_top with hlen 16; the doubled sync then spans the whole pass
`timescale 1ns/1ps
`include "video_defs.svh"

module arcade_video_tb
    import video_pkg::*;
;

    localparam int hlen = 16;
    localparam int line_cycles = hlen * 4;  // pxl_cen every 4 clocks

    logic        clk_sys = 1'b0;
    logic        rst_n;
    logic        pxl_cen = 1'b0;
    logic        pxl2_cen = 1'b0;
    logic [7:0]  pxl = 8'd0;
    logic        hs = 1'b0;
    logic        vs;
    logic [31:0] status;
    logic        game_pause;
    logic [5:0]  vga_r;
    logic [5:0]  vga_g;
    logic [5:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_cen;
    level_e      dip_level;
    logic [1:0]  dip_lives;
    logic        dip_pause;
    logic        rst_req;

    logic [31:0]        lfsr = 32'h302c_df88;
    logic               run_en = 1'b0;
    logic [5:0]         cyc = 6'd0;
    int                 line_count = 0;
    logic [hlen*8-1:0]  cur_line = '0;
    logic [hlen*8-1:0]  send_q[$];  // Lines waiting for the driver
    logic [hlen*8-1:0]  ref_q[$];   // Lines expected on VGA

    arcade_video_top #(
        .hlen (hlen)
    ) UUT (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .pxl2_cen   (pxl2_cen),
        .pxl        (pxl),
        .hs         (hs),
        .vs         (vs),
        .status     (status),
        .game_pause (game_pause),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs),
        .vga_cen    (vga_cen),
        .dip_level  (dip_level),
        .dip_lives  (dip_lives),
        .dip_pause  (dip_pause),
        .rst_req    (rst_req)
    );

    bind arcade_video_top arcade_video_chk u_chk (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .pxl2_cen   (pxl2_cen),
        .line_valid (u_doubler.line_valid_now),
        .rd_done    (u_doubler.rd_done_now),
        .vga_cen    (vga_cen),
        .vga_hs     (vga_hs)
    );

    always #50 clk_sys = ~clk_sys;

    // One native line every 64 clocks
    always @(negedge clk_sys) begin
        if (run_en) begin
            if (cyc == 6'd0) begin
                cur_line = (send_q.size() > 0) ? send_q.pop_front() : '0;
                line_count <= line_count + 1;
            end
            pxl2_cen <= (cyc[0] == 1'b0);
            pxl_cen  <= (cyc[1:0] == 2'd0);
            hs       <= (cyc < 6'd4);  // Short pulse with its rising edge at pixel 0
            pxl      <= cur_line[int'(cyc[5:2]) * 8 +: 8];
            cyc      <= cyc + 6'd1;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_line(output logic [hlen*8-1:0] line);
        line = '0;
        for (int i = 0; i < hlen * 8; i++) begin
            lfsr = lfsr_step(lfsr);
            line = {line[hlen*8-2:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_level(input level_e got, input level_e exp, input string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t ns: %s got %s expected %s",
                                $time, what, got.name(), exp.name()));
    endtask

    task automatic check_two(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t ns: %s got %0d expected %0d",
                                $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t ns: %s got %b expected %b",
                                $time, what, got, exp));
    endtask

    task automatic check_color(input logic [5:0] got, input logic [5:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t ns: %s got %0d expected %0d",
                                $time, what, got, exp));
    endtask

    // Drive on the falling edge and read outputs one clock later
    task automatic apply_status(input logic [31:0] s, input logic gp);
        @(negedge clk_sys);
        status     = s;
        game_pause = gp;
        @(negedge clk_sys);
    endtask

    task automatic wait_line(input int target);
        int cycles;
        cycles = 0;
        while (line_count < target) begin
            @(posedge clk_sys);
            cycles++;
            if (cycles > 4 * line_cycles)
                abort_run("Timed out waiting for the next native line");
        end
    endtask

    // Sends a line, then a filler, and checks both passes of the first one
    task automatic play_and_check(input logic [hlen*8-1:0] line, input logic dim_on,
                                  input string name);
        logic [hlen*8-1:0] filler;
        logic [hlen*8-1:0] exp_line;
        logic [7:0]        p;
        logic [5:0]        er;
        logic [5:0]        eg;
        logic [5:0]        eb;
        int                base;
        int                n;
        int                cycles;
        int                idx;
        random_line(filler);
        @(posedge clk_sys);
        base = line_count;
        send_q.push_back(line);
        ref_q.push_back(line);
        send_q.push_back(filler);
        wait_line(base + 2);
        exp_line = ref_q.pop_front();
        n = 0;
        cycles = 0;
        while (n < 2 * hlen) begin
            @(negedge clk_sys);
            cycles++;
            if (cycles > 2 * line_cycles)
                abort_run($sformatf("Timed out waiting for vga_cen in %s", name));
            if (vga_cen) begin
                idx = n % hlen;
                p  = exp_line[idx * 8 +: 8];
                er = 6'(p[7:5]) * 6'd9;   // 3 bits repeated twice
                eg = 6'(p[4:2]) * 6'd9;
                eb = 6'(p[1:0]) * 6'd21;  // 2 bits repeated three times
                if (dim_on && n >= hlen) begin
                    er = er / 6'd2;
                    eg = eg / 6'd2;
                    eb = eb / 6'd2;
                end
                check_color(vga_r, er, $sformatf("%s red sample %0d", name, n));
                check_color(vga_g, eg, $sformatf("%s green sample %0d", name, n));
                check_color(vga_b, eb, $sformatf("%s blue sample %0d", name, n));
                check_bit(vga_hs, idx < `X2_HS_LEN, $sformatf("%s hs sample %0d", name, n));
                n++;
            end
        end
    endtask

    task automatic test_reset_state;
        check_color(vga_r, 6'd0, "reset red");
        check_color(vga_g, 6'd0, "reset green");
        check_color(vga_b, 6'd0, "reset blue");
        check_bit(vga_hs, 1'b0, "reset vga_hs");
        check_level(dip_level, LEVEL_NORMAL, "reset dip_level");
        check_bit(dip_pause, 1'b0, "reset dip_pause");
        check_bit(rst_req, 1'b0, "reset rst_req");
    endtask

    task automatic test_settings;
        level_e menu_map [4];
        menu_map = '{LEVEL_NORMAL, LEVEL_EASY, LEVEL_HARD, LEVEL_VERY_HARD};
        for (int c = 0; c < 4; c++) begin
            apply_status(32'(c) << `ST_LEVEL_LO, 1'b0);
            check_level(dip_level, menu_map[c], $sformatf("menu level code %0d", c));
            apply_status(32'(c) << `ST_LIVES_LO, 1'b0);
            check_two(dip_lives, 2'(c), $sformatf("lives code %0d", c));
        end
        apply_status(32'd1 << `ST_RESET, 1'b0);
        check_bit(rst_req, 1'b1, "reset request");
        check_bit(dip_pause, 1'b0, "pause with reset only");
        apply_status(32'd1 << `ST_PAUSE, 1'b0);
        check_bit(dip_pause, 1'b1, "menu pause alone");
        check_bit(rst_req, 1'b0, "reset request cleared");
        apply_status(32'd0, 1'b1);
        check_bit(dip_pause, 1'b1, "game pause alone");
        apply_status(32'd1 << `ST_PAUSE, 1'b1);
        check_bit(dip_pause, 1'b1, "both pause sources");
        apply_status(32'd0, 1'b0);
        check_bit(dip_pause, 1'b0, "pause released");
    endtask

    task automatic test_vs_follow;
        apply_status(status, game_pause);
        vs = 1'b1;
        @(negedge clk_sys);
        check_bit(vga_vs, 1'b1, "vga_vs rise");
        vs = 1'b0;
        @(negedge clk_sys);
        check_bit(vga_vs, 1'b0, "vga_vs fall");
    endtask

    initial begin
        logic [hlen*8-1:0] line;
        rst_n      = 1'b0;
        vs         = 1'b0;
        status     = 32'd0;
        game_pause = 1'b0;
        repeat (3) @(negedge clk_sys);
        rst_n = 1'b1;
        test_reset_state();
        @(posedge clk_sys);
        run_en = 1'b1;

        test_settings();

        // Filter off for the plain checks
        apply_status(32'd1 << `ST_FILTER, 1'b0);
        random_line(line);
        play_and_check(line, 1'b0, "doubling");

        play_and_check({(hlen/2){8'hff, 8'h00}}, 1'b0, "fixed colours");
        random_line(line);
        play_and_check(line, 1'b0, "expansion");

        apply_status(32'd0, 1'b0);
        random_line(line);
        play_and_check(line, 1'b1, "scan-line filter");

        test_vs_follow();
        random_line(line);
        play_and_check(line, 1'b1, "doubled sync");

        $display("TESTS PASSED");
        $finish;
    end

endmodule
